// File: common/dii_pkg.sv
/* dii package: flit and id widths, flit positions inside a packet,
   header match helper used by the ring routers */
`default_nettype none

package dii_pkg;

  // data bits of one flit, last travels beside it
  localparam int flit_width = 16;

  // port id width, whole first flit is the destination
  localparam int id_width = 16;

  // flit index inside a packet
  localparam int dest_flit = 0; // destination id
  localparam int src_flit  = 1; // source id, payload after this

  // header flit addressed to id?
  // no subnet split, all id bits compared
  function automatic logic dest_match(
    input logic [flit_width-1:0] flit,
    input logic [id_width-1:0]   id
  );
    return flit[id_width-1:0] == id;
  endfunction

endpackage

`default_nettype wire

// File: debug_ring/dii_buffer.sv
/* dii_buffer: small circular flit FIFO of last/data pairs,
   valid/ready handshake on input and output */
`default_nettype none

module dii_buffer #(
  parameter int BUFFER_SIZE = 4
) (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic                           in_valid,
  input  logic                           in_last,
  input  logic [dii_pkg::flit_width-1:0] in_data,
  output logic                           in_ready,
  output logic                           out_valid,
  output logic                           out_last,
  output logic [dii_pkg::flit_width-1:0] out_data,
  input  logic                           out_ready
);
  import dii_pkg::*;

  localparam int AW = $clog2(BUFFER_SIZE);     // pointer width
  localparam int CW = $clog2(BUFFER_SIZE + 1); // count reaches BUFFER_SIZE

  logic                  mem_last [BUFFER_SIZE];
  logic [flit_width-1:0] mem_data [BUFFER_SIZE];
  logic [AW-1:0]         rd_ptr;
  logic [AW-1:0]         wr_ptr;
  logic [CW-1:0]         count;
  logic                  push;
  logic                  pop;

  // wrap at BUFFER_SIZE, depth need not be a power of two
  function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
    return (p == AW'(BUFFER_SIZE - 1)) ? '0 : p + 1'b1;
  endfunction

  assign in_ready  = count < CW'(BUFFER_SIZE); // room for one more
  assign out_valid = count != '0;
  assign out_last  = mem_last[rd_ptr];          // head of queue
  assign out_data  = mem_data[rd_ptr];

  assign push = in_valid & in_ready;
  assign pop  = out_valid & out_ready;

  // flit storage, written at wr_ptr
  always_ff @(posedge clk) begin
    if (push) begin
      mem_last[wr_ptr] <= in_last;
      mem_data[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= ptr_inc(wr_ptr);
      if (pop)  rd_ptr <= ptr_inc(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ; // both or none, level unchanged
      endcase
    end
  end

endmodule

`default_nettype wire

// File: debug_ring/ring_router_demux.sv
/* ring_router_demux: per-packet steering of one chain,
   deliver to the local port or forward along the chain */
`default_nettype none

module ring_router_demux (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic [dii_pkg::id_width-1:0]   local_id,
  input  logic                           in_valid,
  input  logic                           in_last,
  input  logic [dii_pkg::flit_width-1:0] in_data,
  output logic                           in_ready,
  output logic                           deliver_valid,
  output logic                           deliver_last,
  output logic [dii_pkg::flit_width-1:0] deliver_data,
  input  logic                           deliver_ready,
  output logic                           forward_valid,
  output logic                           forward_last,
  output logic [dii_pkg::flit_width-1:0] forward_data,
  input  logic                           forward_ready
);
  import dii_pkg::*;

  logic in_packet;  // header already passed, body follows
  logic route_q;    // 1 = deliver, latched at the header
  logic hdr_match;
  logic sel;

  // only meaningful while in_data is a header flit
  assign hdr_match = dest_match(in_data, local_id);

  // header decides directly, body flits follow the latched choice
  assign sel = in_packet ? route_q : hdr_match;

  // both sides see the same flit, only one gets valid
  assign deliver_valid = in_valid & sel;
  assign deliver_last  = in_last;
  assign deliver_data  = in_data;
  assign forward_valid = in_valid & ~sel;
  assign forward_last  = in_last;
  assign forward_data  = in_data;

  assign in_ready = sel ? deliver_ready : forward_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      in_packet <= 1'b0;
      route_q   <= 1'b0;
    end else if (in_valid && in_ready) begin
      in_packet <= ~in_last; // last flit closes the packet
      route_q   <= sel;
    end
  end

endmodule

`default_nettype wire

// File: debug_ring/ring_router_mux.sv
/* two-input round-robin flit stream merge
   grant held until the granted packet's last flit */
`default_nettype none

module ring_router_mux (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic                           a_valid,
  input  logic                           a_last,
  input  logic [dii_pkg::flit_width-1:0] a_data,
  output logic                           a_ready,
  input  logic                           b_valid,
  input  logic                           b_last,
  input  logic [dii_pkg::flit_width-1:0] b_data,
  output logic                           b_ready,
  output logic                           out_valid,
  output logic                           out_last,
  output logic [dii_pkg::flit_width-1:0] out_data,
  input  logic                           out_ready
);

  logic locked;   // grant held until the granted last flit
  logic owner;    // 0 = a, 1 = b
  logic rr_ptr;   // preferred input when both wait
  logic pick;
  logic sel;

  // free choice takes the only one waiting, else the round-robin pointer
  always_comb begin
    if (a_valid && b_valid) pick = rr_ptr;
    else if (b_valid)       pick = 1'b1;
    else                    pick = 1'b0;
  end

  assign sel = locked ? owner : pick;

  assign out_valid = sel ? b_valid : a_valid;
  assign out_last  = out_valid & (sel ? b_last : a_last); // last only on an offered flit
  assign out_data  = sel ? b_data  : a_data;

  assign a_ready = out_ready & ~sel;
  assign b_ready = out_ready & sel;

  // lock as soon as a flit is offered, so a stalled flit never changes
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      locked <= 1'b0;
      owner  <= 1'b0;
      rr_ptr <= 1'b0;
    end else if (out_valid) begin
      if (out_ready && out_last) begin
        locked <= 1'b0;
        rr_ptr <= ~sel; // other side first next time
      end else begin
        locked <= 1'b1;
        owner  <= sel;
      end
    end
  end

endmodule

`default_nettype wire

// File: debug_ring/ring_router.sv
/* ring_router: one ring stop, buffered chain and local inputs,
   per-chain demux, merge of deliveries and of chain 0 with injection */
`default_nettype none

module ring_router #(
  parameter int BUFFER_SIZE = 4
) (
  input  logic                                clk,
  input  logic                                arst_n,
  input  logic [dii_pkg::id_width-1:0]        local_id,
  input  logic                                local_in_valid,
  input  logic                                local_in_last,
  input  logic [dii_pkg::flit_width-1:0]      local_in_data,
  output logic                                local_in_ready,
  output logic                                local_out_valid,
  output logic                                local_out_last,
  output logic [dii_pkg::flit_width-1:0]      local_out_data,
  input  logic                                local_out_ready,
  input  logic [1:0]                          ring_in_valid,
  input  logic [1:0]                          ring_in_last,
  input  logic [1:0][dii_pkg::flit_width-1:0] ring_in_data,
  output logic [1:0]                          ring_in_ready,
  output logic [1:0]                          ring_out_valid,
  output logic [1:0]                          ring_out_last,
  output logic [1:0][dii_pkg::flit_width-1:0] ring_out_data,
  input  logic [1:0]                          ring_out_ready
);
  import dii_pkg::*;

  // buffered chain inputs
  logic [1:0]                 buf_valid, buf_last, buf_ready;
  logic [1:0][flit_width-1:0] buf_data;
  // demux outputs per chain
  logic [1:0]                 dlv_valid, dlv_last, dlv_ready;
  logic [1:0][flit_width-1:0] dlv_data;
  logic [1:0]                 fwd_valid, fwd_last, fwd_ready;
  logic [1:0][flit_width-1:0] fwd_data;
  // buffered local injection
  logic                       inj_valid, inj_last, inj_ready;
  logic [flit_width-1:0]      inj_data;

  for (genvar c = 0; c < 2; c++) begin : g_chain
    dii_buffer #(.BUFFER_SIZE(BUFFER_SIZE)) u_buf (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (ring_in_valid[c]),
      .in_last   (ring_in_last[c]),
      .in_data   (ring_in_data[c]),
      .in_ready  (ring_in_ready[c]),
      .out_valid (buf_valid[c]),
      .out_last  (buf_last[c]),
      .out_data  (buf_data[c]),
      .out_ready (buf_ready[c])
    );

    ring_router_demux u_demux (
      .clk           (clk),
      .arst_n        (arst_n),
      .local_id      (local_id),
      .in_valid      (buf_valid[c]),
      .in_last       (buf_last[c]),
      .in_data       (buf_data[c]),
      .in_ready      (buf_ready[c]),
      .deliver_valid (dlv_valid[c]),
      .deliver_last  (dlv_last[c]),
      .deliver_data  (dlv_data[c]),
      .deliver_ready (dlv_ready[c]),
      .forward_valid (fwd_valid[c]),
      .forward_last  (fwd_last[c]),
      .forward_data  (fwd_data[c]),
      .forward_ready (fwd_ready[c])
    );
  end

  dii_buffer #(.BUFFER_SIZE(BUFFER_SIZE)) u_local_buf (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (local_in_valid),
    .in_last   (local_in_last),
    .in_data   (local_in_data),
    .in_ready  (local_in_ready),
    .out_valid (inj_valid),
    .out_last  (inj_last),
    .out_data  (inj_data),
    .out_ready (inj_ready)
  );

  // deliveries from both chains share the local port
  ring_router_mux u_local_mux (
    .clk       (clk),
    .arst_n    (arst_n),
    .a_valid   (dlv_valid[0]),
    .a_last    (dlv_last[0]),
    .a_data    (dlv_data[0]),
    .a_ready   (dlv_ready[0]),
    .b_valid   (dlv_valid[1]),
    .b_last    (dlv_last[1]),
    .b_data    (dlv_data[1]),
    .b_ready   (dlv_ready[1]),
    .out_valid (local_out_valid),
    .out_last  (local_out_last),
    .out_data  (local_out_data),
    .out_ready (local_out_ready)
  );

  // injection joins chain 0 behind this stop's demux
  ring_router_mux u_chain0_mux (
    .clk       (clk),
    .arst_n    (arst_n),
    .a_valid   (fwd_valid[0]),
    .a_last    (fwd_last[0]),
    .a_data    (fwd_data[0]),
    .a_ready   (fwd_ready[0]),
    .b_valid   (inj_valid),
    .b_last    (inj_last),
    .b_data    (inj_data),
    .b_ready   (inj_ready),
    .out_valid (ring_out_valid[0]),
    .out_last  (ring_out_last[0]),
    .out_data  (ring_out_data[0]),
    .out_ready (ring_out_ready[0])
  );

  // chain 1 carries no injection, straight through
  assign ring_out_valid[1] = fwd_valid[1];
  assign ring_out_last[1]  = fwd_last[1];
  assign ring_out_data[1]  = fwd_data[1];
  assign fwd_ready[1]      = ring_out_ready[1];

endmodule

`default_nettype wire

// File: debug_ring/debug_ring_expand.sv
/* debug_ring_expand: PORTS ring stops chained into two rings,
   chain ends left open as ext ports */
`default_nettype none

module debug_ring_expand #(
  parameter int PORTS       = 1,
  parameter int BUFFER_SIZE = 4
) (
  input  logic                                     clk,
  input  logic                                     arst_n,
  input  logic [PORTS-1:0][dii_pkg::id_width-1:0]   id_map,
  input  logic [PORTS-1:0]                         dii_in_valid,
  input  logic [PORTS-1:0]                         dii_in_last,
  input  logic [PORTS-1:0][dii_pkg::flit_width-1:0] dii_in_data,
  output logic [PORTS-1:0]                         dii_in_ready,
  output logic [PORTS-1:0]                         dii_out_valid,
  output logic [PORTS-1:0]                         dii_out_last,
  output logic [PORTS-1:0][dii_pkg::flit_width-1:0] dii_out_data,
  input  logic [PORTS-1:0]                         dii_out_ready,
  input  logic [1:0]                               ext_in_valid,
  input  logic [1:0]                               ext_in_last,
  input  logic [1:0][dii_pkg::flit_width-1:0]       ext_in_data,
  output logic [1:0]                               ext_in_ready,
  output logic [1:0]                               ext_out_valid,
  output logic [1:0]                               ext_out_last,
  output logic [1:0][dii_pkg::flit_width-1:0]       ext_out_data,
  input  logic [1:0]                               ext_out_ready
);
  import dii_pkg::*;

  // link i enters stop i, link PORTS leaves the last stop
  logic [PORTS:0][1:0]                 link_valid;
  logic [PORTS:0][1:0]                 link_last;
  logic [PORTS:0][1:0][flit_width-1:0] link_data;
  logic [PORTS:0][1:0]                 link_ready;

  assign link_valid[0] = ext_in_valid;
  assign link_last[0]  = ext_in_last;
  assign link_data[0]  = ext_in_data;
  assign ext_in_ready  = link_ready[0];

  assign ext_out_valid     = link_valid[PORTS];
  assign ext_out_last      = link_last[PORTS];
  assign ext_out_data      = link_data[PORTS];
  assign link_ready[PORTS] = ext_out_ready;

  for (genvar i = 0; i < PORTS; i++) begin : g_stop
    ring_router #(.BUFFER_SIZE(BUFFER_SIZE)) u_router (
      .clk             (clk),
      .arst_n          (arst_n),
      .local_id        (id_map[i]),
      .local_in_valid  (dii_in_valid[i]),
      .local_in_last   (dii_in_last[i]),
      .local_in_data   (dii_in_data[i]),
      .local_in_ready  (dii_in_ready[i]),
      .local_out_valid (dii_out_valid[i]),
      .local_out_last  (dii_out_last[i]),
      .local_out_data  (dii_out_data[i]),
      .local_out_ready (dii_out_ready[i]),
      .ring_in_valid   (link_valid[i]),
      .ring_in_last    (link_last[i]),
      .ring_in_data    (link_data[i]),
      .ring_in_ready   (link_ready[i]),
      .ring_out_valid  (link_valid[i+1]),
      .ring_out_last   (link_last[i+1]),
      .ring_out_data   (link_data[i+1]),
      .ring_out_ready  (link_ready[i+1])
    );
  end

endmodule

`default_nettype wire

// File: hdl/debug_ring.sv
/* debug_ring: top level, chain 0 end looped into chain 1,
   chain 0 input idle, chain 1 end drained */
`default_nettype none

module debug_ring #(
  parameter int PORTS       = 1,
  parameter int BUFFER_SIZE = 4
) (
  input  logic                                     clk,
  input  logic                                     arst_n,
  input  logic [PORTS-1:0][dii_pkg::id_width-1:0]   id_map,
  input  logic [PORTS-1:0]                         dii_in_valid,
  input  logic [PORTS-1:0]                         dii_in_last,
  input  logic [PORTS-1:0][dii_pkg::flit_width-1:0] dii_in_data,
  output logic [PORTS-1:0]                         dii_in_ready,
  output logic [PORTS-1:0]                         dii_out_valid,
  output logic [PORTS-1:0]                         dii_out_last,
  output logic [PORTS-1:0][dii_pkg::flit_width-1:0] dii_out_data,
  input  logic [PORTS-1:0]                         dii_out_ready
);
  import dii_pkg::*;

  logic [1:0]                 ext_in_valid, ext_in_last, ext_in_ready;
  logic [1:0][flit_width-1:0] ext_in_data;
  logic [1:0]                 ext_out_valid, ext_out_last, ext_out_ready;
  logic [1:0][flit_width-1:0] ext_out_data;

  debug_ring_expand #(
    .PORTS       (PORTS),
    .BUFFER_SIZE (BUFFER_SIZE)
  ) u_ring (
    .clk           (clk),
    .arst_n        (arst_n),
    .id_map        (id_map),
    .dii_in_valid  (dii_in_valid),
    .dii_in_last   (dii_in_last),
    .dii_in_data   (dii_in_data),
    .dii_in_ready  (dii_in_ready),
    .dii_out_valid (dii_out_valid),
    .dii_out_last  (dii_out_last),
    .dii_out_data  (dii_out_data),
    .dii_out_ready (dii_out_ready),
    .ext_in_valid  (ext_in_valid),
    .ext_in_last   (ext_in_last),
    .ext_in_data   (ext_in_data),
    .ext_in_ready  (ext_in_ready),
    .ext_out_valid (ext_out_valid),
    .ext_out_last  (ext_out_last),
    .ext_out_data  (ext_out_data),
    .ext_out_ready (ext_out_ready)
  );

  // nothing enters chain 0 from outside
  assign ext_in_valid[0] = 1'b0;
  assign ext_in_last[0]  = 1'b0;
  assign ext_in_data[0]  = '0;

  // end of chain 0 feeds the start of chain 1
  assign ext_in_valid[1]  = ext_out_valid[0];
  assign ext_in_last[1]   = ext_out_last[0];
  assign ext_in_data[1]   = ext_out_data[0];
  assign ext_out_ready[0] = ext_in_ready[1]; // back-pressure from chain 1

  // unclaimed packets fall off the end of chain 1
  assign ext_out_ready[1] = 1'b1;

endmodule

`default_nettype wire

// File: verification/debug_ring_props.sv
/* concurrent handshake checks on the ring's local outputs
   and their bind into the top level */
`default_nettype none

module debug_ring_props #(
  parameter int PORTS = 1
) (
  input logic                                     clk,
  input logic                                     arst_n,
  input logic [PORTS-1:0]                         dii_out_valid,
  input logic [PORTS-1:0]                         dii_out_last,
  input logic [PORTS-1:0][dii_pkg::flit_width-1:0] dii_out_data,
  input logic [PORTS-1:0]                         dii_out_ready
);
  timeunit 1ns;
  timeprecision 100ps;

  for (genvar p = 0; p < PORTS; p++) begin : g_port
    // buffers empty while in reset
    valid_low_in_reset: assert property (@(posedge clk) !arst_n |-> !dii_out_valid[p])
      else $error("port %0d offers a flit while in reset", p);

    // stalled flit held as is
    stable_while_stalled: assert property (@(posedge clk) disable iff (!arst_n)
      dii_out_valid[p] && !dii_out_ready[p] |=>
        dii_out_valid[p] && $stable(dii_out_data[p]) && $stable(dii_out_last[p]))
      else $error("port %0d changed a stalled flit", p);

    // last only ever marks an offered flit
    last_only_with_valid: assert property (@(posedge clk) disable iff (!arst_n)
      dii_out_last[p] |-> dii_out_valid[p])
      else $error("port %0d raises last without valid", p);
  end

endmodule

bind debug_ring debug_ring_props #(.PORTS(PORTS)) props_i (
  .clk           (clk),
  .arst_n        (arst_n),
  .dii_out_valid (dii_out_valid),
  .dii_out_last  (dii_out_last),
  .dii_out_data  (dii_out_data),
  .dii_out_ready (dii_out_ready)
);

`default_nettype wire

// File: verification/debug_ring_tb.sv
/* testbench for the debug ring
   senders and receivers, reference routing model, compare tasks, directed tests, watchdog */
`default_nettype none

module debug_ring_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import dii_pkg::*;

  localparam int PORTS       = 4;
  localparam int BUFFER_SIZE = 4;
  localparam int max_payload = 4;
  localparam int max_pkt_len = 2 + max_payload;   // dest + src + payload
  localparam int rand_pkts   = 40;
  localparam int total_pkts  = 1 + 1 + 4 + 6 + rand_pkts;
  localparam int cycle_limit = 40 * total_pkts * max_pkt_len;

  logic                             clk;
  logic                             arst_n;
  logic [PORTS-1:0][id_width-1:0]   id_map;
  logic [PORTS-1:0]                 dii_in_valid;
  logic [PORTS-1:0]                 dii_in_last;
  logic [PORTS-1:0][flit_width-1:0] dii_in_data;
  logic [PORTS-1:0]                 dii_in_ready;
  logic [PORTS-1:0]                 dii_out_valid;
  logic [PORTS-1:0]                 dii_out_last;
  logic [PORTS-1:0][flit_width-1:0] dii_out_data;
  logic [PORTS-1:0]                 dii_out_ready;

  // flits kept as {last, data}
  logic [flit_width:0] tx_q  [PORTS][$];        // waiting for injection
  logic [flit_width:0] rx_q  [PORTS][$];        // packet being collected
  logic [flit_width:0] exp_q [PORTS*PORTS][$];  // dest*PORTS + src
  int                  exp_count [PORTS];
  int                  rx_count  [PORTS];
  logic [PORTS-1:0]    hold_ready;              // force a port's ready low
  logic                rand_ready;
  integer              seed = 8411;
  int                  errors = 0;
  int                  errors_at_start;
  int                  tests_run = 0;
  int                  tests_failed = 0;
  int                  cycles = 0;
  string               test_name = "reset";

  initial clk = 1'b0;
  always #50 clk = ~clk;

  debug_ring #(
    .PORTS       (PORTS),
    .BUFFER_SIZE (BUFFER_SIZE)
  ) dut_i (
    .clk           (clk),
    .arst_n        (arst_n),
    .id_map        (id_map),
    .dii_in_valid  (dii_in_valid),
    .dii_in_last   (dii_in_last),
    .dii_in_data   (dii_in_data),
    .dii_in_ready  (dii_in_ready),
    .dii_out_valid (dii_out_valid),
    .dii_out_last  (dii_out_last),
    .dii_out_data  (dii_out_data),
    .dii_out_ready (dii_out_ready)
  );

  task automatic check_flit(input logic [flit_width-1:0] exp_data, input logic exp_last,
                            input logic [flit_width-1:0] act_data, input logic act_last);
    if (act_data !== exp_data || act_last !== exp_last) begin
      $display("mismatch %s: expected flit %h last %b, actual flit %h last %b",
               test_name, exp_data, exp_last, act_data, act_last);
      errors++;
    end
  endtask

  task automatic check_count(input int port, input int exp_pkts, input int act_pkts);
    if (act_pkts != exp_pkts) begin
      $display("mismatch %s: port %0d expected %0d packets, actual %0d",
               test_name, port, exp_pkts, act_pkts);
      errors++;
    end
  endtask

  // compare a whole delivered packet with the oldest one expected from its source
  task automatic verify_packet(input int p);
    logic [flit_width:0] f;
    int                  s;
    s = -1;
    if (rx_q[p].size() < 2) begin
      $display("error %s: port %0d got a packet shorter than its header", test_name, p);
      errors++;
      return;
    end
    for (int i = 0; i < PORTS; i++)
      if (id_map[i] == rx_q[p][src_flit][id_width-1:0]) s = i;
    if (s < 0) begin
      $display("error %s: port %0d got a packet with an unknown source id", test_name, p);
      errors++;
      return;
    end
    for (int i = 0; i < rx_q[p].size(); i++) begin
      if (exp_q[p*PORTS+s].size() == 0) begin
        $display("error %s: port %0d got a packet from port %0d that was never expected",
                 test_name, p, s);
        errors++;
        return;
      end
      f = exp_q[p*PORTS+s].pop_front();
      check_flit(f[flit_width-1:0], f[flit_width],
                 rx_q[p][i][flit_width-1:0], rx_q[p][i][flit_width]);
    end
  endtask

  // senders offer each queue head until the ring takes it
  always @(posedge clk) begin
    for (int p = 0; p < PORTS; p++) begin
      if (dii_in_valid[p] && dii_in_ready[p]) tx_q[p].delete(0); // accepted
      if (arst_n && tx_q[p].size() != 0) begin
        dii_in_valid[p] <= 1'b1;
        dii_in_last[p]  <= tx_q[p][0][flit_width];
        dii_in_data[p]  <= tx_q[p][0][flit_width-1:0];
      end else begin
        dii_in_valid[p] <= 1'b0;
      end
    end
  end

  // receivers close a packet at its last flit
  always @(posedge clk) begin
    for (int p = 0; p < PORTS; p++) begin
      if (dii_out_valid[p] && dii_out_ready[p]) begin
        rx_q[p].push_back({dii_out_last[p], dii_out_data[p]});
        if (dii_out_last[p]) begin
          verify_packet(p);
          rx_q[p].delete();
          rx_count[p]++;
        end
      end
    end
  end

  always @(posedge clk) begin : ready_drive
    logic [31:0] r;
    for (int p = 0; p < PORTS; p++) begin
      if (hold_ready[p]) begin
        dii_out_ready[p] <= 1'b0;
      end else if (rand_ready) begin
        r = $random(seed);
        dii_out_ready[p] <= r[3];
      end else begin
        dii_out_ready[p] <= 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout: %0d cycles passed and test %s still had packets in flight",
               cycle_limit, test_name);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // build a packet, queue it at src and record where the id_map says it lands
  task automatic queue_packet(input int src, input logic [id_width-1:0] dest,
                              input int payload);
    logic [flit_width:0] pkt [max_pkt_len];
    logic [31:0]         r;
    int                  d;
    d = -1;
    pkt[dest_flit] = {1'b0, dest};
    pkt[src_flit]  = {payload == 0, id_map[src]};
    for (int i = 0; i < payload; i++) begin
      r = $random(seed);
      pkt[src_flit+1+i] = {i == payload - 1, r[flit_width-1:0]};
    end
    for (int i = 0; i < PORTS; i++)
      if (id_map[i] == dest) d = i; // no match means dropped at end of chain 1
    for (int i = 0; i < 2 + payload; i++) begin
      tx_q[src].push_back(pkt[i]);
      if (d >= 0) exp_q[d*PORTS+src].push_back(pkt[i]);
    end
    if (d >= 0) exp_count[d]++;
  endtask

  // done once every queue is empty and nothing is being offered
  task automatic wait_drained();
    logic busy;
    busy = 1'b1;
    while (busy) begin
      @(posedge clk);
      busy = 1'b0;
      for (int p = 0; p < PORTS; p++)
        if (tx_q[p].size() != 0 || rx_q[p].size() != 0 || dii_in_valid[p]) busy = 1'b1;
      for (int i = 0; i < PORTS*PORTS; i++)
        if (exp_q[i].size() != 0) busy = 1'b1;
    end
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = errors;
    for (int p = 0; p < PORTS; p++) begin
      exp_count[p] = 0;
      rx_count[p]  = 0;
    end
  endtask

  task automatic finish_test();
    for (int p = 0; p < PORTS; p++) check_count(p, exp_count[p], rx_count[p]);
    tests_run++;
    if (errors != errors_at_start) tests_failed++;
    $display("test %s: %s, %0d errors", test_name,
             (errors == errors_at_start) ? "ok" : "failed", errors - errors_at_start);
  endtask

  task automatic forward_chain0();
    start_test("forward_chain0");
    queue_packet(0, id_map[2], 3);
    wait_drained();
    finish_test();
  endtask

  task automatic wrap_to_chain1();
    start_test("wrap_to_chain1");
    queue_packet(3, id_map[1], 2);
    wait_drained();
    finish_test();
  endtask

  task automatic loopback_and_unknown();
    start_test("loopback_and_unknown");
    queue_packet(1, id_map[1], 2);  // own id comes back round on chain 1
    queue_packet(1, 16'd99, 3);     // nobody claims it
    queue_packet(1, id_map[3], 1);
    queue_packet(2, id_map[0], 2);
    wait_drained();
    finish_test();
  endtask

  task automatic backpressure();
    start_test("backpressure");
    hold_ready[2] = 1'b1;
    for (int i = 0; i < 6; i++) queue_packet(0, id_map[2], i % (max_payload + 1));
    while (!(dii_in_valid[0] && !dii_in_ready[0])) @(posedge clk); // ring full
    hold_ready[2] = 1'b0;
    wait_drained();
    finish_test();
  endtask

  task automatic random_traffic();
    logic [31:0]         r;
    logic [id_width-1:0] dest;
    start_test("random_traffic");
    rand_ready <= 1'b1;
    for (int i = 0; i < rand_pkts; i++) begin
      r = $random(seed);
      if (!r[4])     dest = id_map[r[3:2]];
      else if (r[2]) dest = 16'd99;    // unknown ids
      else           dest = 16'd200;
      queue_packet(int'(r[1:0]), dest, int'(r[7:5]) % (max_payload + 1));
    end
    wait_drained();
    rand_ready <= 1'b0;
    finish_test();
  endtask

  initial begin
    arst_n        = 1'b0;
    dii_in_valid  = '0;
    dii_in_last   = '0;
    dii_in_data   = '0;
    dii_out_ready = '1;
    hold_ready    = '0;
    rand_ready    = 1'b0;
    for (int p = 0; p < PORTS; p++) id_map[p] = id_width'(16 + p); // 16..19
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    forward_chain0();
    wrap_to_chain1();
    loopback_and_unknown();
    backpressure();
    random_traffic();
    $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
common/dii_pkg.sv
debug_ring/dii_buffer.sv
debug_ring/ring_router_demux.sv
debug_ring/ring_router_mux.sv
debug_ring/ring_router.sv
debug_ring/debug_ring_expand.sv
hdl/debug_ring.sv
verification/debug_ring_props.sv
verification/debug_ring_tb.sv

// File: Makefile
VERILATOR  := verilator
TOP        := debug_ring_tb
FILELIST   := sources.f
FLAGS      := --timing --assert --timescale 1ns/100ps
SIM_FLAGS  := --binary $(FLAGS)
LINT_FLAGS := --lint-only $(FLAGS)
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := === FAIL ===
PASS_MSG   := === PASS ===

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then echo "simulator exited with status $$status"; exit 1; fi; \
	if grep -qF "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
